/* theiaPkg.sv */
// --------------------------------------------------
// Shared widths, row type and host address map
// Host address holds component in [1:0], row in [5:2]
// Component field 3 is a hole and is never written
// Upper host address bits are ignored by the core
// --------------------------------------------------

package theiaPkg;

  // --------------------------------------------------
  // Host bus
  // --------------------------------------------------
  localparam int WbWidth = 32;         // Wishbone data and address

  // --------------------------------------------------
  // Scene rows
  // --------------------------------------------------
  localparam int CompWidth = 32;       // One vector component
  localparam int Components = 3;       // x, y, z

  localparam int RowAddrWidth = 4;     // Row index inside a bank
  localparam int RowsPerBank = 2 ** RowAddrWidth;

  // One scene row, component 0 in the low word
  typedef logic [Components-1:0][CompWidth-1:0] rowT;

  // --------------------------------------------------
  // Frame and output memory
  // --------------------------------------------------
  localparam int PairCount = 8;        // Row pairs per frame
  localparam int OmemAddrWidth = 3;    // One result per pair

  // --------------------------------------------------
  // Host address map
  // --------------------------------------------------
  localparam int CompLsb = 0;          // Component field lsb
  localparam int CompFieldWidth = 2;   // Bits 1..0
  localparam int RowLsb = 2;           // Row field lsb, bits 5..2

endpackage

/* sceneMemory.sv */
// --------------------------------------------------
// Double-buffered scene memory, two banks of 16 rows
// Loader writes the bank that is not selected
// Reads always come from the selected bank
// Written data shows up on reads only after a flip
// --------------------------------------------------
`timescale 1ns/10ps

module sceneMemory (
  input  logic                              Clock,
  input  logic                              rstN,
  input  logic                              flip,    // Swap banks, one cycle strobe
  input  logic                              wrEn,
  input  logic [theiaPkg::RowAddrWidth-1:0] wrRow,
  input  logic [theiaPkg::Components-1:0]   wrLane,  // One-hot component mask
  input  logic [theiaPkg::CompWidth-1:0]    wrData,
  input  logic [theiaPkg::RowAddrWidth-1:0] rdRowA,
  input  logic [theiaPkg::RowAddrWidth-1:0] rdRowB,
  output theiaPkg::rowT                     rowA,
  output theiaPkg::rowT                     rowB
);

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------
  theiaPkg::rowT bank0 [theiaPkg::RowsPerBank];
  theiaPkg::rowT bank1 [theiaPkg::RowsPerBank];

  logic bankSel;                  // Compute bank, 0 after reset

  // Bank select toggles on every flip
  always_ff @(posedge Clock or negedge rstN) begin
    if (!rstN) begin
      bankSel <= 1'b0;
    end else if (flip) begin
      bankSel <= ~bankSel;
    end
  end

  // --------------------------------------------------
  // Lane-masked write into the loading bank
  // --------------------------------------------------
  always_ff @(posedge Clock) begin
    for (int lane = 0; lane < theiaPkg::Components; lane++) begin
      if (wrEn && wrLane[lane]) begin
        if (bankSel) begin
          bank0[wrRow][lane] <= wrData;   // Bank 1 computing
        end else begin
          bank1[wrRow][lane] <= wrData;   // Bank 0 computing
        end
      end
    end
  end

  // --------------------------------------------------
  // Two registered read ports, compute bank only
  // --------------------------------------------------
  always_ff @(posedge Clock) begin
    if (bankSel) begin
      rowA <= bank1[rdRowA];
      rowB <= bank1[rdRowB];
    end else begin
      rowA <= bank0[rdRowA];
      rowB <= bank0[rdRowB];
    end
  end

endmodule

/* hostLoader.sv */
// --------------------------------------------------
// Wishbone slave write port for the scene loader
// One ack per request, the cycle after it is seen
// Host must drop wbStb in the cycle after wbAck
// Reads and component field 3 are acked, no effect
// --------------------------------------------------
`timescale 1ns/10ps

module hostLoader (
  input  logic                              Clock,
  input  logic                              rstN,
  input  logic [theiaPkg::WbWidth-1:0]      wbAdr,
  input  logic [theiaPkg::WbWidth-1:0]      wbDat,
  input  logic                              wbWe,
  input  logic                              wbStb,
  input  logic                              wbCyc,
  output logic                              wbAck,
  output logic                              wrEn,
  output logic [theiaPkg::RowAddrWidth-1:0] wrRow,
  output logic [theiaPkg::Components-1:0]   wrLane,
  output logic [theiaPkg::CompWidth-1:0]    wrData
);

  logic                                  request;   // New, not yet acked
  logic [theiaPkg::CompFieldWidth-1:0]   compField;
  logic [theiaPkg::RowAddrWidth-1:0]     rowField;
  logic [theiaPkg::Components-1:0]       laneMask;
  logic                                  compValid; // Field 0..2 only

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------
  assign request   = wbStb && wbCyc && !wbAck;  // Block a second ack
  assign compField = wbAdr[theiaPkg::CompLsb +: theiaPkg::CompFieldWidth];
  assign rowField  = wbAdr[theiaPkg::RowLsb +: theiaPkg::RowAddrWidth];

  always_comb begin
    laneMask = '0;
    for (int lane = 0; lane < theiaPkg::Components; lane++) begin
      if (compField == theiaPkg::CompFieldWidth'(lane)) begin
        laneMask[lane] = 1'b1;
      end
    end
  end

  assign compValid = |laneMask;   // Field 3 decodes to no lane

  // --------------------------------------------------
  // Ack and write strobes, aligned to each other
  // --------------------------------------------------
  always_ff @(posedge Clock or negedge rstN) begin
    if (!rstN) begin
      wbAck  <= 1'b0;
      wrEn   <= 1'b0;
      wrLane <= '0;
    end else begin
      wbAck  <= request;
      wrEn   <= request && wbWe && compValid;
      wrLane <= (request && wbWe) ? laneMask : '0;
    end
  end

  // Payload, qualified by wrEn
  always_ff @(posedge Clock) begin
    wrRow  <= rowField;
    wrData <= wbDat[theiaPkg::CompWidth-1:0];
  end

endmodule

/* vectorExecUnit.sv */
// --------------------------------------------------
// Fixed dot-product pipeline over eight row pairs
// Pair k reads rows 2k and 2k+1, result to address k
// Issue, read, multiply, sum: 3 cycles issue to write
// start to finish is always 11 cycles
// start must not repeat while a frame is running
// --------------------------------------------------
`timescale 1ns/10ps

module vectorExecUnit (
  input  logic                               Clock,
  input  logic                               rstN,
  input  logic                               start,
  output logic [theiaPkg::RowAddrWidth-1:0]  rdRowA,
  output logic [theiaPkg::RowAddrWidth-1:0]  rdRowB,
  input  theiaPkg::rowT                      rowA,
  input  theiaPkg::rowT                      rowB,
  output logic [theiaPkg::CompWidth-1:0]     omemData,
  output logic [theiaPkg::OmemAddrWidth-1:0] omemAddr,
  output logic                               omemWe,
  output logic                               finish
);

  localparam logic [theiaPkg::OmemAddrWidth-1:0] LastPair =
    theiaPkg::OmemAddrWidth'(theiaPkg::PairCount - 1);

  logic                               busy;        // Pairs 1..7 pending
  logic [theiaPkg::OmemAddrWidth-1:0] pairCnt;
  logic [theiaPkg::OmemAddrWidth-1:0] issueIdx;
  logic                               issueValid;

  logic                               readValid;   // Row data stage
  logic [theiaPkg::OmemAddrWidth-1:0] readIdx;
  logic                               prodValid;   // Product stage
  logic [theiaPkg::OmemAddrWidth-1:0] prodIdx;
  theiaPkg::rowT                      prodQ;
  logic [theiaPkg::CompWidth-1:0]     prodSum;

  // --------------------------------------------------
  // Issue, pair 0 goes out in the start cycle
  // --------------------------------------------------
  always_ff @(posedge Clock or negedge rstN) begin
    if (!rstN) begin
      busy    <= 1'b0;
      pairCnt <= '0;
    end else if (start) begin
      busy    <= 1'b1;
      pairCnt <= theiaPkg::OmemAddrWidth'(1);
    end else if (busy) begin
      pairCnt <= pairCnt + 1'b1;
      if (pairCnt == LastPair) begin
        busy <= 1'b0;               // Last pair issued
      end
    end
  end

  assign issueValid = start || busy;
  assign issueIdx   = busy ? pairCnt : '0;
  assign rdRowA     = {issueIdx, 1'b0};   // Row 2k
  assign rdRowB     = {issueIdx, 1'b1};   // Row 2k+1

  // --------------------------------------------------
  // Valid and index shift line
  // --------------------------------------------------
  always_ff @(posedge Clock or negedge rstN) begin
    if (!rstN) begin
      readValid <= 1'b0;
      prodValid <= 1'b0;
      omemWe    <= 1'b0;
      finish    <= 1'b0;
    end else begin
      readValid <= issueValid;
      prodValid <= readValid;
      omemWe    <= prodValid;
      finish    <= omemWe && (omemAddr == LastPair);  // After last write
    end
  end

  // --------------------------------------------------
  // Multiply and accumulate, wrapping 32 bit
  // --------------------------------------------------
  always_ff @(posedge Clock) begin
    readIdx <= issueIdx;
    prodIdx <= readIdx;
    for (int c = 0; c < theiaPkg::Components; c++) begin
      prodQ[c] <= rowA[c] * rowB[c];     // Low word kept
    end
    omemAddr <= prodIdx;
    omemData <= prodSum;
  end

  always_comb begin
    prodSum = '0;
    for (int c = 0; c < theiaPkg::Components; c++) begin
      prodSum = prodSum + prodQ[c];
    end
  end

endmodule

/* coreControl.sv */
// --------------------------------------------------
// Frame FSM for the host handshake
// hostDataAvail is taken only in idle or done
// flip and dataLatched are one strobe, start follows
// resultCommit and done rise the cycle after finish
// --------------------------------------------------
`timescale 1ns/10ps

module coreControl (
  input  logic Clock,
  input  logic rstN,
  input  logic hostDataAvail,
  input  logic finish,
  output logic flip,
  output logic dataLatched,
  output logic start,
  output logic resultCommit,
  output logic done
);

  typedef enum logic [1:0] {
    StIdle,
    StLatch,     // Banks swapped, start next
    StRun,       // Executor busy
    StDone       // Results committed
  } stateT;

  stateT state;
  stateT nextState;
  logic  accept;       // Data available, frame not running
  logic  flipQ;
  logic  startQ;
  logic  commitQ;

  assign accept = hostDataAvail && ((state == StIdle) || (state == StDone));

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb begin
    nextState = state;
    case (state)
      StIdle:  if (accept) nextState = StLatch;
      StLatch: nextState = StRun;
      StRun:   if (finish) nextState = StDone;
      StDone:  if (accept) nextState = StLatch;
      default: nextState = StIdle;
    endcase
  end

  // --------------------------------------------------
  // State and registered strobes
  // --------------------------------------------------
  always_ff @(posedge Clock or negedge rstN) begin
    if (!rstN) begin
      state   <= StIdle;
      flipQ   <= 1'b0;
      startQ  <= 1'b0;
      commitQ <= 1'b0;
    end else begin
      state   <= nextState;
      flipQ   <= accept;
      startQ  <= (state == StLatch);
      commitQ <= (state == StRun) && finish;
    end
  end

  assign flip         = flipQ;
  assign dataLatched  = flipQ;             // Host view of the latch
  assign start        = startQ;
  assign resultCommit = commitQ;
  assign done         = (state == StDone); // Held until next accept

endmodule

/* theiaCore.sv */
// --------------------------------------------------
// Ray-cast core slice, top level
// Host loads one bank while the executor reads the other
// Wishbone slave is write only, reads return no data
// Output memory takes every write, no back-pressure
// --------------------------------------------------
`timescale 1ns/10ps

module theiaCore (
  input  logic                               Clock,
  input  logic                               rstN,
  input  logic [theiaPkg::WbWidth-1:0]       wbAdr,
  input  logic [theiaPkg::WbWidth-1:0]       wbDat,
  input  logic                               wbWe,
  input  logic                               wbStb,
  input  logic                               wbCyc,
  output logic                               wbAck,
  input  logic                               hostDataAvail,
  output logic                               dataLatched,
  output logic                               resultCommit,
  output logic                               done,
  output logic [theiaPkg::CompWidth-1:0]     omemData,
  output logic [theiaPkg::OmemAddrWidth-1:0] omemAddr,
  output logic                               omemWe
);

  // --------------------------------------------------
  // Internal wires
  // --------------------------------------------------
  logic                              flip;      // Control to memory
  logic                              start;     // Control to executor
  logic                              finish;    // Executor to control
  logic                              wrEn;
  logic [theiaPkg::RowAddrWidth-1:0] wrRow;
  logic [theiaPkg::Components-1:0]   wrLane;
  logic [theiaPkg::CompWidth-1:0]    wrData;
  logic [theiaPkg::RowAddrWidth-1:0] rdRowA;
  logic [theiaPkg::RowAddrWidth-1:0] rdRowB;
  theiaPkg::rowT                     rowA;
  theiaPkg::rowT                     rowB;

  coreControl CU (
    .Clock         (Clock),
    .rstN          (rstN),
    .hostDataAvail (hostDataAvail),
    .finish        (finish),
    .flip          (flip),
    .dataLatched   (dataLatched),
    .start         (start),
    .resultCommit  (resultCommit),
    .done          (done)
  );

  hostLoader IO (
    .Clock  (Clock),
    .rstN   (rstN),
    .wbAdr  (wbAdr),
    .wbDat  (wbDat),
    .wbWe   (wbWe),
    .wbStb  (wbStb),
    .wbCyc  (wbCyc),
    .wbAck  (wbAck),
    .wrEn   (wrEn),
    .wrRow  (wrRow),
    .wrLane (wrLane),
    .wrData (wrData)
  );

  vectorExecUnit EXE (
    .Clock    (Clock),
    .rstN     (rstN),
    .start    (start),
    .rdRowA   (rdRowA),
    .rdRowB   (rdRowB),
    .rowA     (rowA),
    .rowB     (rowB),
    .omemData (omemData),
    .omemAddr (omemAddr),
    .omemWe   (omemWe),
    .finish   (finish)
  );

  sceneMemory MEM (
    .Clock  (Clock),
    .rstN   (rstN),
    .flip   (flip),
    .wrEn   (wrEn),
    .wrRow  (wrRow),
    .wrLane (wrLane),
    .wrData (wrData),
    .rdRowA (rdRowA),
    .rdRowB (rdRowB),
    .rowA   (rowA),
    .rowB   (rowB)
  );

endmodule

/* theiaCore_asserts.sv */
// --------------------------------------------------
// Protocol checks on the core boundary
// Bound into every theiaCore instance
// All checks are off while rstN is low
// failCount keeps the number of failed checks
// --------------------------------------------------
`timescale 1ns/10ps

module theiaCoreAsserts (
  input logic Clock,
  input logic rstN,
  input logic wbStb,
  input logic wbCyc,
  input logic wbAck,
  input logic dataLatched,
  input logic resultCommit,
  input logic omemWe,
  input logic done
);

  int   failCount = 0;
  logic commitPending;      // Latched, not yet committed
  int   waitCycles;

  // Cycles from dataLatched to resultCommit
  always_ff @(posedge Clock or negedge rstN) begin
    if (!rstN) begin
      commitPending <= 1'b0;
      waitCycles    <= 0;
    end else if (dataLatched) begin
      commitPending <= 1'b1;
      waitCycles    <= 0;
    end else if (resultCommit) begin
      commitPending <= 1'b0;
    end else if (commitPending) begin
      waitCycles <= waitCycles + 1;
    end
  end

  // --------------------------------------------------
  // Host bus
  // --------------------------------------------------
  ackAfterRequest: assert property (@(posedge Clock) disable iff (!rstN)
    wbAck |-> $past(wbStb && wbCyc))
    else begin
      failCount++;
      $error("wbAck without a request");
    end

  requestAcked: assert property (@(posedge Clock) disable iff (!rstN)
    (wbStb && wbCyc && !wbAck) |=> wbAck)
    else begin
      failCount++;
      $error("request not acked in the next cycle");
    end

  ackSingle: assert property (@(posedge Clock) disable iff (!rstN)
    wbAck |=> !wbAck)
    else begin
      failCount++;
      $error("wbAck longer than one cycle");
    end

  // --------------------------------------------------
  // Frame handshake
  // --------------------------------------------------
  latchSingle: assert property (@(posedge Clock) disable iff (!rstN)
    dataLatched |=> !dataLatched)
    else begin
      failCount++;
      $error("dataLatched longer than one cycle");
    end

  commitSingle: assert property (@(posedge Clock) disable iff (!rstN)
    resultCommit |=> !resultCommit)
    else begin
      failCount++;
      $error("resultCommit longer than one cycle");
    end

  noWriteWhenDone: assert property (@(posedge Clock) disable iff (!rstN)
    !(omemWe && done))
    else begin
      failCount++;
      $error("omemWe while done is high");
    end

  commitInTime: assert property (@(posedge Clock) disable iff (!rstN)
    commitPending |-> (waitCycles < 15))
    else begin
      failCount++;
      $error("no resultCommit within 15 cycles of dataLatched");
    end

endmodule

bind theiaCore theiaCoreAsserts coreAsserts (
  .Clock        (Clock),
  .rstN         (rstN),
  .wbStb        (wbStb),
  .wbCyc        (wbCyc),
  .wbAck        (wbAck),
  .dataLatched  (dataLatched),
  .resultCommit (resultCommit),
  .omemWe       (omemWe),
  .done         (done)
);

/* tbTheiaCore.sv */
// --------------------------------------------------
// Testbench for theiaCore, frame loads and dot products
// Frame data from a 16 bit LFSR, seed 67
// Inputs change on the rising edge, outputs read on the falling edge
// Protocol checks come from the bound assertion module
// --------------------------------------------------
`timescale 1ns/10ps

module tbTheiaCore;

  logic                               Clock = 1'b0;
  logic                               rstN;
  logic [theiaPkg::WbWidth-1:0]       wbAdr;
  logic [theiaPkg::WbWidth-1:0]       wbDat;
  logic                               wbWe;
  logic                               wbStb;
  logic                               wbCyc;
  logic                               hostDataAvail;
  logic                               wbAck;
  logic                               dataLatched;
  logic                               resultCommit;
  logic                               done;
  logic                               omemWe;
  logic [theiaPkg::CompWidth-1:0]     omemData;
  logic [theiaPkg::OmemAddrWidth-1:0] omemAddr;

  logic [15:0] lfsrState;
  // Frame, row, component
  logic [31:0] frameData [2][theiaPkg::RowsPerBank][theiaPkg::Components];
  logic [31:0] resAddr [$];         // Every omemWe write seen
  logic [31:0] resData [$];
  int ackCount = 0;
  int latchCount = 0;
  int commitCount = 0;
  int weCount = 0;
  int weAtCommit = 0;
  int errCount = 0;
  int testErrStart = 0;
  int testCount = 0;
  int failedTests = 0;

  theiaCore UUT (.*);

  always #20 Clock = ~Clock;        // 40 ns period

  // --------------------------------------------------
  // Monitor, counts strobes at the falling edge
  // --------------------------------------------------
  always @(negedge Clock) begin
    if (rstN) begin
      if (wbAck) ackCount++;
      if (dataLatched) latchCount++;
      if (omemWe) begin
        weCount++;
        resAddr.push_back(32'(omemAddr));
        resData.push_back(omemData);
      end
      if (resultCommit) begin
        commitCount++;
        weAtCommit = weCount;       // Writes done before this commit
      end
    end
  end

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] randomWord();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsrState = lfsrNext(lfsrState);   // One step per bit
      w = {w[30:0], lfsrState[0]};
    end
    return w;
  endfunction

  // Reference, wrapping sum of component products of rows 2k and 2k+1
  function automatic logic [31:0] dotRef(input int f, input int k);
    logic [31:0] acc;
    acc = '0;
    for (int c = 0; c < theiaPkg::Components; c++) begin
      acc = acc + frameData[f][2 * k][c] * frameData[f][2 * k + 1][c];
    end
    return acc;
  endfunction

  task automatic checkValue(input string testName, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("error %s expected %0h actual %0h", testName, expected, actual);
      errCount++;
    end
  endtask

  task automatic checkTrue(input string testName, input bit cond, input string what);
    assert (cond) else begin
      $display("%s %s", testName, what);
      errCount++;
    end
  endtask

  task automatic finishTest(input string testName);
    testCount++;
    if (errCount == testErrStart) begin
      $display("test %s passed", testName);
    end else begin
      $display("test %s failed", testName);
      failedTests++;
    end
    testErrStart = errCount;
  endtask

  // --------------------------------------------------
  // Host side
  // --------------------------------------------------
  task automatic busCycle(input logic [31:0] adr, input logic [31:0] dat, input logic we);
    int waited;
    @(posedge Clock);
    wbAdr <= adr;
    wbDat <= dat;
    wbWe  <= we;
    wbStb <= 1'b1;
    wbCyc <= 1'b1;
    waited = 0;
    do begin
      @(negedge Clock);
      waited++;
    end while (!wbAck && waited < 8);
    if (!wbAck) begin
      $display("timeout, no wbAck for address %0h", adr);
      errCount++;
    end
    @(posedge Clock);
    wbStb <= 1'b0;                  // Drop in the cycle after ack
    wbCyc <= 1'b0;
    wbWe  <= 1'b0;
  endtask

  // Top row first, the executor reads the top pair last
  task automatic loadFrame(input int f);
    logic [31:0] word;
    for (int row = theiaPkg::RowsPerBank - 1; row >= 0; row--) begin
      for (int c = 0; c < theiaPkg::Components; c++) begin
        word = randomWord();
        frameData[f][row][c] = word;
        busCycle((row << theiaPkg::RowLsb) | (c << theiaPkg::CompLsb), word, 1'b1);
      end
    end
  endtask

  task automatic pulseAvail();
    @(posedge Clock);
    hostDataAvail <= 1'b1;
    @(posedge Clock);
    hostDataAvail <= 1'b0;
  endtask

  task automatic waitCommits(input int target);
    int waited;
    waited = 0;
    while (commitCount < target && waited < 200) begin
      @(posedge Clock);
      waited++;
    end
    if (commitCount < target) begin
      $display("timeout waiting for resultCommit number %0d", target);
      errCount++;
    end
  endtask

  task automatic waitLatches(input int target);
    int waited;
    waited = 0;
    while (latchCount < target && waited < 20) begin
      @(posedge Clock);
      waited++;
    end
    if (latchCount < target) begin
      $display("timeout waiting for dataLatched number %0d", target);
      errCount++;
    end
  endtask

  task automatic checkResults(input string testName, input int f, input int base);
    for (int k = 0; k < theiaPkg::PairCount; k++) begin
      if (base + k < resData.size()) begin
        checkValue(testName, k, resAddr[base + k]);
        checkValue(testName, dotRef(f, k), resData[base + k]);
      end else begin
        checkTrue(testName, 1'b0, "is missing an omemWe write");
      end
    end
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    rstN = 1'b0;
    wbAdr = '0;
    wbDat = '0;
    wbWe = 1'b0;
    wbStb = 1'b0;
    wbCyc = 1'b0;
    hostDataAvail = 1'b0;
    lfsrState = 16'd67;
    repeat (4) @(posedge Clock);
    rstN <= 1'b1;

    @(negedge Clock);
    checkTrue("reset", !wbAck && !dataLatched && !resultCommit && !omemWe && !done,
              "has an output high after reset");
    finishTest("reset");

    loadFrame(0);                                   // Frame one, 48 writes
    busCycle((5 << theiaPkg::RowLsb) | 3, 32'hdead_beef, 1'b1);  // Component hole
    busCycle(32'h0, 32'h0, 1'b0);                   // Read cycle
    checkValue("hostAcks", 50, ackCount);
    finishTest("hostAcks");

    pulseAvail();
    loadFrame(1);                                   // Frame two, during the run
    waitCommits(1);
    checkResults("frameOne", 0, 0);
    checkValue("frameOne", 8, weCount);
    finishTest("frameOne");

    checkValue("commitDone", 8, weAtCommit);
    repeat (3) begin
      @(negedge Clock);
      checkTrue("commitDone", done, "saw done drop before hostDataAvail");
    end
    pulseAvail();
    @(negedge Clock);
    checkTrue("commitDone", !done, "kept done high after hostDataAvail");
    finishTest("commitDone");

    waitLatches(2);
    repeat (3) @(posedge Clock);
    pulseAvail();                                   // Lands in the run state
    waitCommits(2);
    checkResults("frameTwo", 1, 8);
    checkValue("frameTwo", 16, weAtCommit);
    finishTest("frameTwo");

    repeat (20) @(posedge Clock);
    checkValue("ignoredAvail", 16, weCount);
    checkValue("ignoredAvail", 2, commitCount);
    checkValue("ignoredAvail", 2, latchCount);
    checkTrue("ignoredAvail", done, "has done low after the last frame");
    finishTest("ignoredAvail");

    $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
             testCount, failedTests, errCount, UUT.coreAsserts.failCount);
    if (errCount == 0 && UUT.coreAsserts.failCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* sources.f */
theiaPkg.sv
sceneMemory.sv
hostLoader.sv
vectorExecUnit.sv
coreControl.sv
theiaCore.sv
theiaCore_asserts.sv
tbTheiaCore.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tbTheiaCore
FILELIST  := sources.f
RUNARGS   := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	out=$$(./obj_dir/V$(TOP) $(RUNARGS)); echo "$$out"; echo "$$out" | grep -qx "No errors"

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir
